/* hw/rom_pkg.sv */
package rom_pkg;

	// SDRAM geometry, one bank in use
	typedef logic [12:0] row_t;
	typedef logic [8:0]  col_t;
	typedef logic [21:0] sdram_addr_t;  // Row above column

	typedef logic [15:0] word_t;
	typedef logic [15:0] port_addr_t;   // Word offset inside a port region
	typedef logic [1:0]  port_idx_t;

	// {cs_n, ras_n, cas_n, we_n}
	typedef logic [3:0] cmd_t;

	localparam cmd_t CMD_LOAD_MODE   = 4'b0000;
	localparam cmd_t CMD_AUTOREFRESH = 4'b0001;
	localparam cmd_t CMD_PRECHARGE   = 4'b0010;
	localparam cmd_t CMD_ACTIVATE    = 4'b0011;
	localparam cmd_t CMD_WRITE       = 4'b0100;
	localparam cmd_t CMD_READ        = 4'b0101;
	localparam cmd_t CMD_NOP         = 4'b0111;
	localparam cmd_t CMD_INHIBIT     = 4'b1000;  // Chip deselected

	typedef enum logic [1:0] {
		SLOT_READ    = 2'd0,
		SLOT_REFRESH = 2'd1,
		SLOT_WRITE   = 2'd2
	} slot_op_t;

	// What the next slot does, and for whom
	typedef struct packed {
		slot_op_t  op;
		port_idx_t port;  // Only meaningful for reads
	} slot_req_t;

	// Read result broadcast to all ports
	typedef struct packed {
		logic      valid;
		port_idx_t port;
		word_t     data;
	} rd_return_t;

	// Read slots per rotation, one refresh follows them
	localparam int ROT_LEN = 8;

	// Port 0 gets every other slot
	localparam port_idx_t SLOT_TABLE [ROT_LEN] = '{
		2'd0, 2'd1, 2'd0, 2'd2, 2'd0, 2'd1, 2'd0, 2'd3
	};

	// 64K words per port
	localparam sdram_addr_t REGION_BASE [4] = '{
		22'h00_0000,
		22'h01_0000,
		22'h02_0000,
		22'h03_0000
	};

	// Slot lengths in clock cycles
	localparam int READ_SLOT_CYC    = 8;
	localparam int WRITE_SLOT_CYC   = 7;
	localparam int REFRESH_SLOT_CYC = 14;

endpackage

/* hw/crc32.sv */
module crc32 (
	input  logic           clk,
	input  logic           rst,
	input  logic           crc_en,
	input  rom_pkg::word_t data,
	output logic [31:0]    crc_out
);

	// 0x04C11DB7 bit reversed
	localparam logic [31:0] POLY_REFL = 32'hedb8_8320;

	logic [31:0] crc;

	// LSB first, low byte before high byte
	function automatic logic [31:0] crc_step(
		input logic [31:0]    c,
		input rom_pkg::word_t d
	);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < $bits(rom_pkg::word_t); i++) begin
			if (r[0] ^ d[i])
				r = (r >> 1) ^ POLY_REFL;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	always_ff @(posedge clk) begin
		if (rst)
			crc <= '1;  // Standard preset
		else if (crc_en)
			crc <= crc_step(crc, data);
	end

	assign crc_out = ~crc;  // Final inversion

endmodule

/* hw/rom_port.sv */
module rom_port #(
	parameter rom_pkg::sdram_addr_t BASE = '0,
	parameter rom_pkg::port_idx_t   IDX  = '0
) (
	input  logic                 clk,
	input  logic                 rst,
	input  rom_pkg::port_addr_t  addr,
	input  logic                 start,
	input  rom_pkg::rd_return_t  ret,
	output rom_pkg::sdram_addr_t req_addr,
	output rom_pkg::word_t       dout
);

	rom_pkg::port_addr_t lat_addr;  // Held for the whole slot

	// The client may change addr at any time, so the controller
	// only ever sees the copy taken when our slot begins
	always_ff @(posedge clk) begin
		if (rst)
			lat_addr <= '0;
		else if (start)
			lat_addr <= addr;
	end

	assign req_addr = BASE + rom_pkg::sdram_addr_t'(lat_addr);

	// Data broadcast goes to every port, keep only ours
	always_ff @(posedge clk) begin
		if (ret.valid && ret.port == IDX)
			dout <= ret.data;
	end

endmodule

/* hw/slot_scheduler.sv */
module slot_scheduler #(
	parameter int N_PORTS = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               downloading,
	input  logic               wr_pending,
	input  logic               slot_done,
	output rom_pkg::slot_req_t next_slot,
	output logic [N_PORTS-1:0] slot_start
);

	localparam int IDX_W = $clog2(rom_pkg::ROT_LEN);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(rom_pkg::ROT_LEN - 1);

	logic [IDX_W-1:0] idx;      // Position in SLOT_TABLE
	logic             refresh;  // Refresh slot is due next

	// Held level, sampled by the controller on slot_done
	always_comb begin
		if (downloading) begin
			if (wr_pending)
				next_slot.op = rom_pkg::SLOT_WRITE;
			else
				next_slot.op = rom_pkg::SLOT_REFRESH;  // Keeps rows alive while idle
			next_slot.port = '0;
		end else if (refresh) begin
			next_slot.op   = rom_pkg::SLOT_REFRESH;
			next_slot.port = '0;
		end else begin
			next_slot.op   = rom_pkg::SLOT_READ;
			next_slot.port = rom_pkg::SLOT_TABLE[idx];
		end
	end

	// Tell the port to freeze its address as its read slot begins
	always_comb begin
		slot_start = '0;
		if (slot_done && next_slot.op == rom_pkg::SLOT_READ)
			slot_start[next_slot.port] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			idx     <= '0;
			refresh <= 1'b0;
		end else if (slot_done) begin
			if (downloading) begin
				// Reads resume with a refresh, then a full rotation
				idx     <= '0;
				refresh <= 1'b1;
			end else if (refresh) begin
				refresh <= 1'b0;
			end else if (idx == LAST_IDX) begin
				idx     <= '0;
				refresh <= 1'b1;  // One refresh per rotation
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

/* hw/sdram_ctrl.sv */
module sdram_ctrl #(
	parameter int N_PORTS   = 4,
	parameter int INIT_WAIT = 8400
) (
	input  logic                 clk,
	input  logic                 rst,
	input  rom_pkg::slot_req_t   next_slot,
	output logic                 slot_done,
	input  rom_pkg::sdram_addr_t req_addr [N_PORTS],
	output rom_pkg::rd_return_t  rd_ret,
	input  logic                 romload_wr,
	input  rom_pkg::sdram_addr_t romload_addr,
	input  rom_pkg::word_t       romload_data,
	output logic                 wr_pending,
	output logic                 crc_en,
	output rom_pkg::word_t       crc_data,
	output logic                 ready,
	inout  rom_pkg::word_t       dq,
	output rom_pkg::row_t        sdram_a,
	output rom_pkg::cmd_t        cmd,
	output logic [1:0]           ba,
	output logic [1:0]           dqm,
	output logic                 cke,
	output logic                 sdram_clk
);

	localparam int WAIT_W = $clog2(INIT_WAIT + 16);

	// WAIT issues n+1 NOPs for a count of n
	localparam logic [WAIT_W-1:0] RD_TAIL = WAIT_W'(rom_pkg::READ_SLOT_CYC - 7);
	localparam logic [WAIT_W-1:0] WR_TAIL = WAIT_W'(rom_pkg::WRITE_SLOT_CYC - 7);
	localparam logic [WAIT_W-1:0] RF_TAIL = WAIT_W'(rom_pkg::REFRESH_SLOT_CYC - 5);
	localparam logic [WAIT_W-1:0] AR_GAP  = WAIT_W'(10);  // 11 NOPs after init refresh

	localparam rom_pkg::row_t A10_ALL = 13'h0400;  // Precharge all banks
	// CL2, burst length 1, single location writes
	localparam rom_pkg::row_t MODE_CL2_BL1 = 13'b000_1_00_010_0_000;

	typedef enum logic [2:0] {
		INIT,
		PRECHARGE,
		ACTIVATE,
		ACCESS,
		WAIT,
		REFRESH,
		DONE
	} state_t;

	state_t               state;
	state_t               nxt;        // Where WAIT goes when the count expires
	logic [2:0]           init_step;
	logic [WAIT_W-1:0]    wait_cnt;
	rom_pkg::slot_req_t   cur;        // Slot being run
	rom_pkg::sdram_addr_t wr_addr;
	rom_pkg::word_t       wr_data;
	rom_pkg::sdram_addr_t sel_addr;
	rom_pkg::row_t        sel_row;
	rom_pkg::col_t        sel_col;
	rom_pkg::word_t       dq_out;
	logic                 dq_oe;
	rom_pkg::word_t       rd_data;
	logic                 rd_valid;

	assign ba        = 2'b00;
	assign dqm       = 2'b00;
	assign cke       = 1'b1;
	assign sdram_clk = clk;

	assign sel_addr = (cur.op == rom_pkg::SLOT_WRITE) ? wr_addr : req_addr[cur.port];
	assign {sel_row, sel_col} = sel_addr;

	assign dq       = dq_oe ? dq_out : 'z;
	assign crc_data = dq_out;  // Same word the SDRAM gets
	assign rd_ret   = '{valid: rd_valid, port: cur.port, data: rd_data};

	always_ff @(posedge clk) begin
		if (romload_wr) begin
			wr_addr <= romload_addr;
			wr_data <= romload_data;
		end
		dq_out  <= wr_data;  // Lines up with the WRITE cycle
		rd_data <= dq;       // CL2 word is valid on the edge into the last read cycle
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= INIT;
			nxt        <= INIT;
			init_step  <= '0;
			wait_cnt   <= WAIT_W'(INIT_WAIT - 1);
			cur        <= '{op: rom_pkg::SLOT_REFRESH, port: '0};
			cmd        <= rom_pkg::CMD_INHIBIT;
			sdram_a    <= '0;
			ready      <= 1'b0;
			slot_done  <= 1'b0;
			rd_valid   <= 1'b0;
			crc_en     <= 1'b0;
			dq_oe      <= 1'b0;
			wr_pending <= 1'b0;
		end else begin
			cmd       <= rom_pkg::CMD_NOP;
			slot_done <= 1'b0;
			rd_valid  <= 1'b0;
			crc_en    <= 1'b0;
			dq_oe     <= 1'b0;
			case (state)
				INIT: begin
					case (init_step)
						3'd0: begin  // Power-up NOPs
							if (wait_cnt == '0)
								init_step <= 3'd1;
							else
								wait_cnt <= wait_cnt - 1'b1;
						end
						3'd1: begin
							cmd       <= rom_pkg::CMD_PRECHARGE;
							sdram_a   <= A10_ALL;
							wait_cnt  <= '0;
							nxt       <= INIT;
							state     <= WAIT;
							init_step <= 3'd2;
						end
						3'd2, 3'd3: begin
							cmd       <= rom_pkg::CMD_AUTOREFRESH;
							wait_cnt  <= AR_GAP;
							nxt       <= INIT;
							state     <= WAIT;
							init_step <= init_step + 1'b1;
						end
						default: begin
							cmd      <= rom_pkg::CMD_LOAD_MODE;
							sdram_a  <= MODE_CL2_BL1;
							ready    <= 1'b1;
							wait_cnt <= '0;  // tMRD, then the first slot is taken
							nxt      <= DONE;
							state    <= WAIT;
						end
					endcase
				end
				PRECHARGE: begin
					cmd      <= rom_pkg::CMD_PRECHARGE;
					sdram_a  <= A10_ALL;
					cur      <= next_slot;
					wait_cnt <= '0;
					if (next_slot.op == rom_pkg::SLOT_REFRESH)
						nxt <= REFRESH;
					else
						nxt <= ACTIVATE;
					state <= WAIT;
				end
				ACTIVATE: begin
					cmd      <= rom_pkg::CMD_ACTIVATE;
					sdram_a  <= sel_row;
					wait_cnt <= '0;  // tRCD
					nxt      <= ACCESS;
					state    <= WAIT;
				end
				ACCESS: begin
					sdram_a <= rom_pkg::row_t'(sel_col);  // A10 low, no auto precharge
					if (cur.op == rom_pkg::SLOT_WRITE) begin
						cmd        <= rom_pkg::CMD_WRITE;
						dq_oe      <= 1'b1;
						crc_en     <= 1'b1;
						wr_pending <= 1'b0;
						wait_cnt   <= WR_TAIL;
					end else begin
						cmd      <= rom_pkg::CMD_READ;
						wait_cnt <= RD_TAIL;
					end
					nxt   <= DONE;
					state <= WAIT;
				end
				REFRESH: begin
					cmd      <= rom_pkg::CMD_AUTOREFRESH;
					wait_cnt <= RF_TAIL;
					nxt      <= DONE;
					state    <= WAIT;
				end
				WAIT: begin
					if (wait_cnt == '0)
						state <= nxt;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				DONE: begin
					slot_done <= 1'b1;
					rd_valid  <= (cur.op == rom_pkg::SLOT_READ);
					state     <= PRECHARGE;
				end
				default: state <= PRECHARGE;
			endcase
			// A new load word wins over one just written
			if (romload_wr)
				wr_pending <= 1'b1;
		end
	end

endmodule

/* hw/rom_subsys.sv */
module rom_subsys #(
	parameter int N_PORTS   = 4,
	parameter int INIT_WAIT = 8400
) (
	input  logic                 clk,
	input  logic                 rst,
	input  rom_pkg::port_addr_t  port_addr [N_PORTS],
	output rom_pkg::word_t       port_dout [N_PORTS],
	input  logic                 downloading,
	input  logic                 romload_wr,
	input  rom_pkg::sdram_addr_t romload_addr,
	input  rom_pkg::word_t       romload_data,
	output logic                 ready,
	output logic [31:0]          crc_out,
	inout  rom_pkg::word_t       dq,
	output rom_pkg::row_t        sdram_a,
	output rom_pkg::cmd_t        cmd,
	output logic [1:0]           ba,
	output logic [1:0]           dqm,
	output logic                 cke,
	output logic                 sdram_clk
);

	rom_pkg::slot_req_t   next_slot;
	logic                 slot_done;
	logic [N_PORTS-1:0]   slot_start;
	rom_pkg::sdram_addr_t req_addr [N_PORTS];
	rom_pkg::rd_return_t  rd_ret;
	logic                 wr_pending;
	logic                 crc_en;
	rom_pkg::word_t       crc_data;

	slot_scheduler #(
		.N_PORTS (N_PORTS)
	) u_sched (
		.clk         (clk),
		.rst         (rst),
		.downloading (downloading),
		.wr_pending  (wr_pending),
		.slot_done   (slot_done),
		.next_slot   (next_slot),
		.slot_start  (slot_start)
	);

	for (genvar i = 0; i < N_PORTS; i++) begin : g_port
		rom_port #(
			.BASE (rom_pkg::REGION_BASE[i]),
			.IDX  (rom_pkg::port_idx_t'(i))
		) u_port (
			.clk      (clk),
			.rst      (rst),
			.addr     (port_addr[i]),
			.start    (slot_start[i]),
			.ret      (rd_ret),
			.req_addr (req_addr[i]),
			.dout     (port_dout[i])
		);
	end

	sdram_ctrl #(
		.N_PORTS   (N_PORTS),
		.INIT_WAIT (INIT_WAIT)
	) u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.next_slot    (next_slot),
		.slot_done    (slot_done),
		.req_addr     (req_addr),
		.rd_ret       (rd_ret),
		.romload_wr   (romload_wr),
		.romload_addr (romload_addr),
		.romload_data (romload_data),
		.wr_pending   (wr_pending),
		.crc_en       (crc_en),
		.crc_data     (crc_data),
		.ready        (ready),
		.dq           (dq),
		.sdram_a      (sdram_a),
		.cmd          (cmd),
		.ba           (ba),
		.dqm          (dqm),
		.cke          (cke),
		.sdram_clk    (sdram_clk)
	);

	crc32 u_crc (
		.clk     (clk),
		.rst     (rst),
		.crc_en  (crc_en),
		.data    (crc_data),
		.crc_out (crc_out)
	);

endmodule

/* tb/sdram_model.sv */
module sdram_model (
	input  logic           clk,
	input  logic           rst,
	input  rom_pkg::cmd_t  cmd,
	input  rom_pkg::row_t  a,
	input  logic [1:0]     ba,
	inout  rom_pkg::word_t dq,
	output logic           err
);

	rom_pkg::word_t mem [logic [23:0]];  // Only written words are stored
	rom_pkg::row_t  open_row;
	logic           row_open;
	logic           rd_pend;             // READ taken on the last edge
	rom_pkg::word_t rd_word;
	logic           drv;
	rom_pkg::word_t drv_word;
	logic [23:0]    key;

	assign dq  = drv ? drv_word : 'z;
	assign key = {ba, open_row, a[8:0]};

	// Unwritten words read back a value tied to every address bit
	function automatic rom_pkg::word_t fill_word(input logic [23:0] k);
		return k[15:0] ^ {k[23:16], k[23:16]};
	endfunction

	task automatic flag(input string what);
		$display("%0t: SDRAM model: %s", $time, what);
		err <= 1'b1;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			row_open <= 1'b0;
			rd_pend  <= 1'b0;
			drv      <= 1'b0;
			err      <= 1'b0;
		end else begin
			rd_pend  <= 1'b0;
			drv      <= rd_pend;  // CL2, word sits on dq in the second cycle
			drv_word <= rd_word;
			case (cmd)
				rom_pkg::CMD_PRECHARGE: row_open <= 1'b0;  // A10 high, all banks
				rom_pkg::CMD_ACTIVATE: begin
					if (row_open)
						flag("ACTIVATE while a row is still open");
					row_open <= 1'b1;
					open_row <= a;
				end
				rom_pkg::CMD_READ: begin
					if (!row_open)
						flag("READ without an ACTIVATE since the last PRECHARGE");
					rd_pend <= 1'b1;
					rd_word <= mem.exists(key) ? mem[key] : fill_word(key);
				end
				rom_pkg::CMD_WRITE: begin
					if (!row_open)
						flag("WRITE without an ACTIVATE since the last PRECHARGE");
					mem[key] = dq;
				end
				rom_pkg::CMD_AUTOREFRESH: begin
					if (row_open)
						flag("AUTOREFRESH while a row is open");
				end
				rom_pkg::CMD_LOAD_MODE: begin
					if (a[6:4] != 3'd2 || a[2:0] != 3'd0)
						flag("mode register not set to CAS latency 2, burst length 1");
				end
				default: ;
			endcase
		end
	end

endmodule

/* tb/rom_subsys_tb.sv */
module rom_subsys_tb;

	localparam int N_PORTS     = 4;
	localparam int INIT_WAIT   = 100;
	localparam int N_LOADS     = 64;
	localparam int PER_PORT    = N_LOADS / N_PORTS;
	localparam int LOAD_GAP    = 40;
	localparam int HOLD_CYC    = 157;   // Two rotations plus one cycle
	localparam int ROT_READS   = 8;
	localparam int N_ROUNDS    = 6;
	localparam int TIMEOUT_CYC = 6000;

	logic                 clk, rst, downloading, romload_wr, ready, model_err;
	rom_pkg::port_addr_t  port_addr [N_PORTS];
	rom_pkg::word_t       port_dout [N_PORTS];
	rom_pkg::sdram_addr_t romload_addr;
	rom_pkg::word_t       romload_data;
	logic [31:0]          crc_out, lfsr;
	wire  [15:0]          dq;
	rom_pkg::row_t        sdram_a;
	rom_pkg::cmd_t        cmd;
	logic [1:0]           ba, dqm;
	logic                 cke, sdram_clk;
	rom_pkg::port_addr_t  base_off [N_PORTS];  // Start of the loaded block per region
	rom_pkg::word_t       ld_data [N_LOADS];
	int                   cycles, init_cyc, writes, acts, ar_seen, sclk_edges;

	rom_subsys #(.N_PORTS(N_PORTS), .INIT_WAIT(INIT_WAIT)) DUT (.*);

	sdram_model u_sdram (
		.clk (clk),
		.rst (rst),
		.cmd (cmd),
		.a   (sdram_a),
		.ba  (ba),
		.dq  (dq),
		.err (model_err)
	);

	always #10 clk = ~clk;

	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		abort_run();
	endtask

	task automatic report_failure(input string msg);
		$display("%0t: %s", $time, msg);
		abort_run();
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
	endfunction

	// One LFSR step per bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	// Ethernet CRC-32 byte by byte with the low byte of each word first
	function automatic logic [31:0] crc_ref();
		logic [31:0] c;
		c = 32'hffff_ffff;
		for (int i = 0; i < N_LOADS; i++) begin
			for (int j = 0; j < 2; j++) begin
				c = c ^ {24'h0, ld_data[i][8*j +: 8]};
				for (int k = 0; k < 8; k++)
					c = c[0] ? (c >> 1) ^ 32'hedb8_8320 : c >> 1;
			end
		end
		return ~c;
	endfunction

	task automatic load_word(input rom_pkg::sdram_addr_t a, input rom_pkg::word_t d);
		romload_addr = a;
		romload_data = d;
		romload_wr   = 1'b1;
		@(negedge clk);
		romload_wr = 1'b0;
		repeat (LOAD_GAP - 1) @(negedge clk);
	endtask

	task automatic read_round(input logic pick);
		int k [N_PORTS];
		for (int p = 0; p < N_PORTS; p++) begin
			k[p] = pick ? int'(take_bits(4)) : 0;
			port_addr[p] = base_off[p] + rom_pkg::port_addr_t'(k[p]);
		end
		repeat (HOLD_CYC) @(negedge clk);
		for (int p = 0; p < N_PORTS; p++) begin
			assert (port_dout[p] === ld_data[p*PER_PORT + k[p]])
			else report_mismatch($sformatf("port %0d read %h, expected %h",
				p, port_dout[p], ld_data[p*PER_PORT + k[p]]));
		end
	endtask

	always @(posedge sdram_clk)
		sclk_edges <= sclk_edges + 1;

	// Bus monitor sees the command of the cycle just ended
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC)
			report_failure("Timeout, the test did not reach its end");
		if (rst) begin
			init_cyc <= 0;
		end else begin
			init_cyc <= init_cyc + 1;
			if (init_cyc < INIT_WAIT) begin
				assert (!ready && (cmd == rom_pkg::CMD_NOP || cmd == rom_pkg::CMD_INHIBIT))
				else report_mismatch($sformatf("cmd %b ready %b in power-up wait", cmd, ready));
			end
			if (init_cyc == INIT_WAIT + 40) begin
				assert (ready) else report_mismatch("ready still low after initialization");
			end
			assert (cke === 1'b1 && dqm === 2'b00 && ba === 2'b00)
			else report_mismatch($sformatf("cke %b dqm %b ba %b not tied off", cke, dqm, ba));
			assert (sclk_edges == cycles)
			else report_mismatch($sformatf("%0d SDRAM clock edges in %0d cycles",
				sclk_edges, cycles));
		end
		if (downloading) begin
			assert (cmd !== rom_pkg::CMD_READ)
			else report_failure("READ command seen during download");
			ar_seen <= 0;
		end else if (cmd == rom_pkg::CMD_AUTOREFRESH) begin
			// First refreshes after download may come back to back
			if (ar_seen >= 2) begin
				assert (acts == ROT_READS)
				else report_mismatch($sformatf("%0d ACTIVATEs between refreshes", acts));
			end
			ar_seen <= ar_seen + 1;
			acts    <= 0;
		end else if (cmd == rom_pkg::CMD_ACTIVATE) begin
			acts <= acts + 1;
		end
		if (cmd == rom_pkg::CMD_WRITE)
			writes <= writes + 1;
	end

	always @(negedge clk) begin
		assert (model_err !== 1'b1)
		else report_failure("SDRAM model saw commands in a wrong order");
	end

	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		downloading  = 1'b1;
		romload_wr   = 1'b0;
		romload_addr = '0;
		romload_data = '0;
		port_addr    = '{default: '0};
		lfsr         = 32'h05a6_a9a6;
		cycles       = 0;
		init_cyc     = 0;
		writes       = 0;
		acts         = 0;
		ar_seen      = 0;
		sclk_edges   = 0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		while (!ready)
			@(negedge clk);
		for (int p = 0; p < N_PORTS; p++) begin
			base_off[p] = rom_pkg::port_addr_t'(take_bits(15));  // Room for the block
			for (int k = 0; k < PER_PORT; k++) begin
				ld_data[p*PER_PORT + k] = rom_pkg::word_t'(take_bits(16));
				load_word(rom_pkg::REGION_BASE[p] + rom_pkg::sdram_addr_t'(base_off[p])
					+ rom_pkg::sdram_addr_t'(k), ld_data[p*PER_PORT + k]);
			end
		end
		while (writes < N_LOADS)
			@(negedge clk);
		assert (crc_out === crc_ref())
		else report_mismatch($sformatf("crc %h, expected %h", crc_out, crc_ref()));
		downloading = 1'b0;
		read_round(1'b0);
		repeat (N_ROUNDS) read_round(1'b1);
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* all.f */
hw/rom_pkg.sv
hw/crc32.sv
hw/rom_port.sv
hw/slot_scheduler.sv
hw/sdram_ctrl.sv
hw/rom_subsys.sv
tb/sdram_model.sv
tb/rom_subsys_tb.sv
